// File: hdl/soc_pkg.sv
package soc_pkg;

  // Bus widths
  localparam int DATA_W     = 16;
  localparam int SEL_W      = 2;
  localparam int CPU_ADDR_W = 19;                  // Word address of the 1 MB space
  localparam int OFFSET_W   = 11;
  localparam int REGION_W   = 1;
  localparam int MEM_AW     = REGION_W + OFFSET_W; // Region then offset

  localparam logic [REGION_W-1:0] REGION_BASE  = 1'b0;
  localparam logic [REGION_W-1:0] REGION_VIDEO = 1'b1;

  // Windows as {tga, word address}
  localparam logic [CPU_ADDR_W:0] VIDEO_ADDR = 20'h5_0000; // mem 0xA0000 - 0xBFFFF
  localparam logic [CPU_ADDR_W:0] VIDEO_MASK = 20'hF_0000;
  localparam logic [CPU_ADDR_W:0] POST_ADDR  = 20'h8_0040; // io 0x80 - 0x81
  localparam logic [CPU_ADDR_W:0] POST_MASK  = 20'h8_7FFF;
  localparam logic [CPU_ADDR_W:0] CTRL_ADDR  = 20'h8_7900; // io 0xF200 - 0xF201
  localparam logic [CPU_ADDR_W:0] CTRL_MASK  = 20'h8_7FFF;

  localparam logic [DATA_W-1:0] UNMAPPED_DATA = 16'hFFFF;

  // Scanout and memory sizing
  localparam int FRAME_WORDS = 16;
  localparam int FIFO_DEPTH  = 4;
  localparam int MEM_LATENCY = 2;                  // Accept to read data
  localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

  localparam logic [FIFO_CNT_W-1:0] FIFO_FULL   = FIFO_CNT_W'(FIFO_DEPTH);
  localparam logic [OFFSET_W-1:0]   LAST_OFFSET = OFFSET_W'(FRAME_WORDS - 1);

  localparam logic TAG_SCAN = 1'b0;
  localparam logic TAG_CPU  = 1'b1;

  // One address word, read as memory or as IO depending on tga
  typedef struct packed {
    logic                  tga;
    logic [CPU_ADDR_W-1:0] wadr;
  } mem_view_t;

  typedef struct packed {
    logic        tga;
    logic [3:0]  pad;
    logic [15:1] port;  // Port number, word granular
  } io_view_t;

  typedef union packed {
    mem_view_t mem;
    io_view_t  io;
  } bus_addr_u;

  typedef struct packed {
    logic              stb;
    logic              we;
    logic [SEL_W-1:0]  sel;
    bus_addr_u         addr;
    logic [DATA_W-1:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic                valid;
    logic                we;
    logic [SEL_W-1:0]    sel;
    logic [REGION_W-1:0] region; // Set by the CPU side, forced for scanout
    logic [OFFSET_W-1:0] offset;
    logic [DATA_W-1:0]   wdata;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic              we;
    logic [SEL_W-1:0]  sel;
    logic [MEM_AW-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              tag;
  } ram_req_t;

  typedef struct packed {
    logic              valid;
    logic              tag;
    logic [DATA_W-1:0] rdata;
  } ram_rsp_t;

endpackage

// File: hdl/cpu_bus_switch.sv
module cpu_bus_switch (
  input  logic                  clk,
  input  logic                  rst_lck,
  input  soc_pkg::cpu_req_t     cpu_req_i,
  output soc_pkg::cpu_rsp_t     cpu_rsp_o,
  output soc_pkg::mem_req_t     mem_req_o,
  input  logic                  mem_grant_i,
  input  soc_pkg::ram_rsp_t     ram_rsp_i,
  output logic [7:0]            postcode_o,
  output logic                  scan_en_o
);

  logic                       is_io;
  logic                       video_hit;
  logic                       post_hit;
  logic                       ctrl_hit;
  logic                       io_take;
  logic                       mem_take;
  logic                       rsp_hit;
  logic                       ack_q;
  logic                       mem_busy_q;  // Read granted, data not back yet
  logic [soc_pkg::DATA_W-1:0] io_rdata;
  logic [soc_pkg::DATA_W-1:0] rdata_q;

  // Address decode
  assign is_io     = cpu_req_i.addr.io.tga;
  assign video_hit = (cpu_req_i.addr & soc_pkg::VIDEO_MASK) == soc_pkg::VIDEO_ADDR;
  assign post_hit  = (cpu_req_i.addr & soc_pkg::POST_MASK) == soc_pkg::POST_ADDR;
  assign ctrl_hit  = (cpu_req_i.addr & soc_pkg::CTRL_MASK) == soc_pkg::CTRL_ADDR;

  assign io_take  = cpu_req_i.stb && is_io && !ack_q;
  assign mem_take = mem_req_o.valid && mem_grant_i;
  assign rsp_hit  = mem_busy_q && ram_rsp_i.valid && (ram_rsp_i.tag == soc_pkg::TAG_CPU);

  // Memory request held until the arbiter grants it
  assign mem_req_o = '{
    valid:  cpu_req_i.stb && !is_io && !mem_busy_q && !ack_q,
    we:     cpu_req_i.we,
    sel:    cpu_req_i.sel,
    region: video_hit ? soc_pkg::REGION_VIDEO : soc_pkg::REGION_BASE,
    offset: cpu_req_i.addr.mem.wadr[soc_pkg::OFFSET_W-1:0], // Aliases inside region
    wdata:  cpu_req_i.wdata
  };

  always_comb begin
    io_rdata = soc_pkg::UNMAPPED_DATA;
    if (post_hit) begin
      io_rdata = {8'h00, postcode_o};
    end else if (ctrl_hit) begin
      io_rdata = {{(soc_pkg::DATA_W-1){1'b0}}, scan_en_o};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q      <= 1'b0;
      mem_busy_q <= 1'b0;
      postcode_o <= 8'h00;
      scan_en_o  <= 1'b0;
    end else begin
      ack_q <= io_take || (mem_take && cpu_req_i.we) || rsp_hit;
      if (mem_take && !cpu_req_i.we) begin
        mem_busy_q <= 1'b1;
      end else if (rsp_hit) begin
        mem_busy_q <= 1'b0;
      end
      // Both registers live in the low byte
      if (io_take && cpu_req_i.we && cpu_req_i.sel[0]) begin
        if (post_hit) postcode_o <= cpu_req_i.wdata[7:0];
        if (ctrl_hit) scan_en_o <= cpu_req_i.wdata[0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (io_take) begin
      rdata_q <= io_rdata;
    end else if (rsp_hit) begin
      rdata_q <= ram_rsp_i.rdata;
    end
  end

  assign cpu_rsp_o = '{ack: ack_q, rdata: rdata_q};

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_lck)
    cpu_rsp_o.ack |=> !cpu_rsp_o.ack);

  a_addr_hold: assert property (@(posedge clk) disable iff (!rst_lck)
    cpu_req_i.stb && !cpu_rsp_o.ack |=> cpu_req_i.stb && $stable(cpu_req_i.addr));

endmodule

// File: hdl/mem_arbiter.sv
module mem_arbiter (
  input  logic               clk,
  input  logic               rst_lck,
  input  soc_pkg::mem_req_t  scan_req_i,
  output logic               scan_grant_o,
  input  soc_pkg::mem_req_t  cpu_req_i,
  output logic               cpu_grant_o,
  output soc_pkg::ram_req_t  ram_req_o
);

  soc_pkg::mem_req_t          win;       // Request picked this cycle
  logic [soc_pkg::MEM_AW-1:0] win_addr;
  logic                       win_tag;

  // Scanout always first
  assign scan_grant_o = scan_req_i.valid;
  assign cpu_grant_o  = cpu_req_i.valid && !scan_req_i.valid;

  always_comb begin
    if (scan_grant_o) begin
      win      = scan_req_i;
      win_addr = {soc_pkg::REGION_VIDEO, scan_req_i.offset};
      win_tag  = soc_pkg::TAG_SCAN;
    end else begin
      win      = cpu_req_i;
      win_addr = {cpu_req_i.region, cpu_req_i.offset}; // Region chosen by the switch
      win_tag  = soc_pkg::TAG_CPU;
    end
  end

  always_ff @(posedge clk) begin
    ram_req_o.we    <= win.we;
    ram_req_o.sel   <= win.sel;
    ram_req_o.addr  <= win_addr;
    ram_req_o.wdata <= win.wdata;
    ram_req_o.tag   <= win_tag;
    if (!rst_lck) begin
      ram_req_o.valid <= 1'b0;
    end else begin
      ram_req_o.valid <= scan_grant_o || cpu_grant_o;
    end
  end

  // Scanout credits leave a free slot at least every FIFO_DEPTH+1 cycles
  a_cpu_wait: assert property (@(posedge clk) disable iff (!rst_lck)
    cpu_req_i.valid |-> ##[0:soc_pkg::FIFO_DEPTH] cpu_grant_o);

endmodule

// File: hdl/scanout_reader.sv
module scanout_reader (
  input  logic                        clk,
  input  logic                        rst_lck,
  input  logic                        scan_en_i,
  output soc_pkg::mem_req_t           mem_req_o,
  input  logic                        mem_grant_i,
  input  soc_pkg::ram_rsp_t           ram_rsp_i,
  output logic [soc_pkg::DATA_W-1:0]  pix_word_o,
  output logic                        pix_valid_o,
  input  logic                        pix_ready_i
);

  logic [soc_pkg::OFFSET_W-1:0]   offset_q;
  logic [soc_pkg::FIFO_CNT_W-1:0] credit_q;  // In flight plus stored
  logic [soc_pkg::FIFO_CNT_W-1:0] fill_q;
  logic [soc_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
  logic [soc_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
  logic [soc_pkg::DATA_W-1:0]     fifo_q [soc_pkg::FIFO_DEPTH];
  logic                           issue;
  logic                           push;
  logic                           pop;

  assign mem_req_o = '{
    valid:  scan_en_i && (credit_q < soc_pkg::FIFO_FULL),
    we:     1'b0,
    sel:    '1,
    region: soc_pkg::REGION_VIDEO,
    offset: offset_q,
    wdata:  '0
  };

  assign issue = mem_req_o.valid && mem_grant_i;
  assign push  = ram_rsp_i.valid && (ram_rsp_i.tag == soc_pkg::TAG_SCAN);
  assign pop   = pix_valid_o && pix_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      offset_q <= '0;
      credit_q <= '0;
      fill_q   <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      case ({issue, pop})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (issue) begin
        offset_q <= (offset_q == soc_pkg::LAST_OFFSET) ? '0 : offset_q + 1'b1;
      end else if (!scan_en_i && credit_q == '0) begin
        offset_q <= '0;  // Drained, next enable starts a new frame
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) fifo_q[wr_ptr_q] <= ram_rsp_i.rdata;
  end

  assign pix_valid_o = (fill_q != '0);
  assign pix_word_o  = fifo_q[rd_ptr_q];

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_lck)
    push |-> fill_q != soc_pkg::FIFO_FULL);

  a_pix_hold: assert property (@(posedge clk) disable iff (!rst_lck)
    pix_valid_o && !pix_ready_i |=> pix_valid_o && $stable(pix_word_o));

endmodule

// File: hdl/shared_mem.sv
module shared_mem (
  input  logic               clk,
  input  logic               rst_lck,
  input  soc_pkg::ram_req_t  ram_req_i,
  output soc_pkg::ram_rsp_t  ram_rsp_o
);

  logic [soc_pkg::DATA_W-1:0]      mem_q [2**soc_pkg::MEM_AW];
  logic [soc_pkg::MEM_LATENCY-1:0] vld_q;
  logic [soc_pkg::MEM_LATENCY-1:0] tag_q;
  logic [soc_pkg::DATA_W-1:0]      data_q [soc_pkg::MEM_LATENCY];
  logic                            rd_en;

  assign rd_en = ram_req_i.valid && !ram_req_i.we;

  // Byte lane writes
  always_ff @(posedge clk) begin
    if (ram_req_i.valid && ram_req_i.we) begin
      for (int b = 0; b < soc_pkg::SEL_W; b++) begin
        if (ram_req_i.sel[b]) begin
          mem_q[ram_req_i.addr][8*b +: 8] <= ram_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read pipeline, stage 0 first
  always_ff @(posedge clk) begin
    tag_q     <= {tag_q[soc_pkg::MEM_LATENCY-2:0], ram_req_i.tag};
    data_q[0] <= mem_q[ram_req_i.addr];
    for (int s = 1; s < soc_pkg::MEM_LATENCY; s++) begin
      data_q[s] <= data_q[s-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[soc_pkg::MEM_LATENCY-2:0], rd_en};
    end
  end

  assign ram_rsp_o = '{
    valid: vld_q[soc_pkg::MEM_LATENCY-1],
    tag:   tag_q[soc_pkg::MEM_LATENCY-1],
    rdata: data_q[soc_pkg::MEM_LATENCY-1]
  };

endmodule

// File: hdl/soc_top.sv
module soc_top (
  input  logic                        clk,
  input  logic                        rst_lck,
  input  soc_pkg::cpu_req_t           cpu_req_i,
  output soc_pkg::cpu_rsp_t           cpu_rsp_o,
  output logic [7:0]                  postcode_o,
  output logic [soc_pkg::DATA_W-1:0]  pix_word_o,
  output logic                        pix_valid_o,
  input  logic                        pix_ready_i
);

  soc_pkg::mem_req_t cpu_mem_req;
  logic              cpu_mem_grant;
  soc_pkg::mem_req_t scan_mem_req;
  logic              scan_mem_grant;
  soc_pkg::ram_req_t ram_req;
  soc_pkg::ram_rsp_t ram_rsp;   // Shared by switch and scanout, split by tag
  logic              scan_en;

  cpu_bus_switch u_switch (
    .clk         (clk),
    .rst_lck     (rst_lck),
    .cpu_req_i   (cpu_req_i),
    .cpu_rsp_o   (cpu_rsp_o),
    .mem_req_o   (cpu_mem_req),
    .mem_grant_i (cpu_mem_grant),
    .ram_rsp_i   (ram_rsp),
    .postcode_o  (postcode_o),
    .scan_en_o   (scan_en)
  );

  mem_arbiter u_arbiter (
    .clk          (clk),
    .rst_lck      (rst_lck),
    .scan_req_i   (scan_mem_req),
    .scan_grant_o (scan_mem_grant),
    .cpu_req_i    (cpu_mem_req),
    .cpu_grant_o  (cpu_mem_grant),
    .ram_req_o    (ram_req)
  );

  scanout_reader u_scanout (
    .clk         (clk),
    .rst_lck     (rst_lck),
    .scan_en_i   (scan_en),
    .mem_req_o   (scan_mem_req),
    .mem_grant_i (scan_mem_grant),
    .ram_rsp_i   (ram_rsp),
    .pix_word_o  (pix_word_o),
    .pix_valid_o (pix_valid_o),
    .pix_ready_i (pix_ready_i)
  );

  shared_mem u_mem (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .ram_req_i (ram_req),
    .ram_rsp_o (ram_rsp)
  );

endmodule

// File: bench/tb_soc_top.sv
module tb_soc_top;
  timeunit 1ns;
  timeprecision 1ps;

  parameter int SEED = 32'h97ea_1701;

  localparam int RESET_CYCLES = 10;
  localparam int BUS_LIMIT    = soc_pkg::FIFO_DEPTH + soc_pkg::MEM_LATENCY + 3;
  localparam int BUS_OPS      = 80;                        // Handshakes over the whole run
  localparam int STREAM_WORDS = soc_pkg::FRAME_WORDS * 5;  // Four frames, then one after restart
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + BUS_OPS * (BUS_LIMIT + 3)
                                 + STREAM_WORDS * 8 + 200;
  localparam int READY_LOW    = 0;
  localparam int READY_HIGH   = 1;
  localparam int READY_RANDOM = 2;

  logic                       clk;
  logic                       rst_lck;
  soc_pkg::cpu_req_t          cpu_req;
  soc_pkg::cpu_rsp_t          cpu_rsp;
  logic [7:0]                 postcode;
  logic [soc_pkg::DATA_W-1:0] pix_word;
  logic                       pix_valid;
  logic                       pix_ready;

  // Reference model and checker state
  logic [15:0] ref_mem [2][2**soc_pkg::OFFSET_W];  // Base and video regions
  logic [7:0]  post_ref;
  logic        ctrl_ref;
  logic [15:0] exp_rdata;
  logic        scan_on;
  logic        frame_restart;
  int          ready_mode = READY_LOW;
  integer      seed;
  int          pix_idx;
  int          pix_count;
  int          words_after_off;
  int          bus_wait;     // Cycles the current strobe has waited
  int          passes = 0;
  int          errors = 0;
  int          stalls = 0;
  int          fails_before = 0;

  soc_top uut (
    .clk         (clk),
    .rst_lck     (rst_lck),
    .cpu_req_i   (cpu_req),
    .cpu_rsp_o   (cpu_rsp),
    .postcode_o  (postcode),
    .pix_word_o  (pix_word),
    .pix_valid_o (pix_valid),
    .pix_ready_i (pix_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Pixel sink back-pressure
  initial begin
    logic [31:0] rnd;
    seed = SEED;
    pix_ready = 1'b0;
    forever begin
      @(negedge clk);
      rnd = $random(seed);
      case (ready_mode)
        READY_HIGH:   pix_ready = 1'b1;
        READY_RANDOM: pix_ready = rnd[0];
        default:      pix_ready = 1'b0;
      endcase
    end
  end

  always @(posedge clk) begin
    if (!rst_lck) begin
      pix_idx         <= 0;
      pix_count       <= 0;
      words_after_off <= 0;
      bus_wait        <= 0;
    end else begin
      if (!cpu_req.stb || cpu_rsp.ack) bus_wait <= 0;
      else bus_wait <= bus_wait + 1;
      if (frame_restart) begin
        pix_idx <= 0;
      end else if (pix_valid && pix_ready) begin
        pix_idx <= (pix_idx + 1) % soc_pkg::FRAME_WORDS;  // Frame wraps
      end
      if (pix_valid && pix_ready) pix_count <= pix_count + 1;
      if (scan_on) words_after_off <= 0;
      else if (pix_valid && pix_ready) words_after_off <= words_after_off + 1;
    end
  end

  a_reset_state: assert property (@(posedge clk)
    $rose(rst_lck) |-> !pix_valid && postcode == 8'h00 && !cpu_rsp.ack) passes++;
  else begin
    errors++;
    $display("Error: after reset pix_valid_o=%h postcode_o=%h ack=%h",
             $sampled(pix_valid), $sampled(postcode), $sampled(cpu_rsp.ack));
  end

  a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_lck)
    cpu_rsp.ack |-> $past(cpu_req.stb)) passes++;
  else begin
    errors++;
    $display("Error: ack=%h without a preceding stb", $sampled(cpu_rsp.ack));
  end

  a_io_latency: assert property (@(posedge clk) disable iff (!rst_lck)
    cpu_rsp.ack && cpu_req.addr.io.tga |-> bus_wait == 1) passes++;
  else begin
    errors++;
    $display("Error: io ack bus_wait=%h, expected %h", $sampled(bus_wait), 1);
  end

  a_bus_latency: assert property (@(posedge clk) disable iff (!rst_lck)
    cpu_req.stb && !cpu_req.addr.mem.tga |-> bus_wait <= BUS_LIMIT) passes++;
  else begin
    errors++;
    $display("Error: memory bus_wait=%h exceeds %h", $sampled(bus_wait), BUS_LIMIT);
  end

  a_read_data: assert property (@(posedge clk) disable iff (!rst_lck)
    cpu_rsp.ack && !cpu_req.we |-> cpu_rsp.rdata == exp_rdata) passes++;
  else begin
    errors++;
    $display("Error: rdata=%h, expected %h", $sampled(cpu_rsp.rdata), $sampled(exp_rdata));
  end

  a_postcode: assert property (@(posedge clk) disable iff (!rst_lck)
    cpu_rsp.ack |-> postcode == post_ref) passes++;
  else begin
    errors++;
    $display("Error: postcode_o=%h, expected %h", $sampled(postcode), $sampled(post_ref));
  end

  a_pix_word: assert property (@(posedge clk) disable iff (!rst_lck)
    pix_valid && pix_ready |-> pix_word == ref_mem[1][pix_idx]) passes++;
  else begin
    errors++;
    $display("Error: pix_word_o=%h, expected %h", $sampled(pix_word),
             ref_mem[1][$sampled(pix_idx)]);
  end

  // Only words already requested may follow a disable
  a_pix_stop: assert property (@(posedge clk) disable iff (!rst_lck)
    pix_valid && pix_ready && !scan_on |-> words_after_off < soc_pkg::FIFO_DEPTH) passes++;
  else begin
    errors++;
    $display("Error: words_after_off=%h after disable, limit %h",
             $sampled(words_after_off), soc_pkg::FIFO_DEPTH);
  end

  function automatic soc_pkg::bus_addr_u mem_addr(input logic [19:0] byte_addr);
    soc_pkg::bus_addr_u a;
    a.mem.tga  = 1'b0;
    a.mem.wadr = byte_addr[19:1];
    return a;
  endfunction

  function automatic soc_pkg::bus_addr_u io_addr(input logic [15:0] port);
    soc_pkg::bus_addr_u a;
    a.io.tga  = 1'b1;
    a.io.pad  = 4'h0;
    a.io.port = port[15:1];
    return a;
  endfunction

  // Video window 0xA0000 to 0xBFFFF in words, all other memory is base
  function automatic int region_of(input soc_pkg::bus_addr_u addr);
    return (addr.mem.wadr >= 19'h5_0000 && addr.mem.wadr <= 19'h5_FFFF) ? 1 : 0;
  endfunction

  function automatic logic [15:0] merge_bytes(input logic [15:0] old_word,
                                              input logic [15:0] new_word,
                                              input logic [1:0]  sel);
    logic [15:0] word;
    word = old_word;
    if (sel[0]) word[7:0] = new_word[7:0];
    if (sel[1]) word[15:8] = new_word[15:8];
    return word;
  endfunction

  function automatic logic [15:0] expected_read(input soc_pkg::bus_addr_u addr);
    if (addr.io.tga) begin
      if (addr.io.port == 15'h0040) return {8'h00, post_ref};
      if (addr.io.port == 15'h7900) return {15'h0000, ctrl_ref};
      return 16'hFFFF;  // Unmapped port
    end
    return ref_mem[region_of(addr)][addr.mem.wadr[soc_pkg::OFFSET_W-1:0]];
  endfunction

  task automatic handshake(input logic we, input soc_pkg::bus_addr_u addr,
                           input logic [1:0] sel, input logic [15:0] wdata);
    int cycles;
    cycles = 0;
    @(negedge clk);
    cpu_req.stb   = 1'b1;
    cpu_req.we    = we;
    cpu_req.sel   = sel;
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    do begin
      @(negedge clk);
      cycles++;
    end while (!cpu_rsp.ack && cycles <= BUS_LIMIT + 2);
    if (!cpu_rsp.ack) begin
      stalls++;
      $display("Bus access to %h was never acknowledged", addr);
    end else begin
      @(negedge clk);  // Strobe stays up across the ack edge
    end
    cpu_req.stb = 1'b0;
  endtask

  task automatic bus_write(input soc_pkg::bus_addr_u addr, input logic [1:0] sel,
                           input logic [15:0] wdata);
    int region;
    if (addr.io.tga) begin
      if (addr.io.port == 15'h0040 && sel[0]) post_ref = wdata[7:0];
      if (addr.io.port == 15'h7900 && sel[0]) ctrl_ref = wdata[0];
    end else begin
      region = region_of(addr);
      ref_mem[region][addr.mem.wadr[soc_pkg::OFFSET_W-1:0]] = merge_bytes(
        ref_mem[region][addr.mem.wadr[soc_pkg::OFFSET_W-1:0]], wdata, sel);
    end
    handshake(1'b1, addr, sel, wdata);
  endtask

  task automatic bus_read(input soc_pkg::bus_addr_u addr);
    exp_rdata = expected_read(addr);
    handshake(1'b0, addr, 2'b11, 16'h0000);
  endtask

  task automatic wait_words(input int n);
    int target;
    int cycles;
    target = pix_count + n;
    cycles = 0;
    while (pix_count < target && cycles < n * 8 + 20) begin
      @(negedge clk);
      cycles++;
    end
    if (pix_count < target) begin
      stalls++;
      $display("Pixel stream stalled at %0d of %0d words", pix_count, target);
    end
  endtask

  // Quiet long enough that no read can still be in flight
  task automatic wait_drain();
    int quiet;
    int cycles;
    quiet = 0;
    cycles = 0;
    while (quiet < soc_pkg::MEM_LATENCY + 2 && cycles < 8 * soc_pkg::FIFO_DEPTH) begin
      @(negedge clk);
      cycles++;
      quiet = pix_valid ? 0 : quiet + 1;
    end
    if (quiet < soc_pkg::MEM_LATENCY + 2) begin
      stalls++;
      $display("Pixel stream kept running after scanout was disabled");
    end
  endtask

  task automatic report_test(input string name);
    int fails;
    fails = errors + stalls - fails_before;
    if (fails == 0) $display("Test %s: ok", name);
    else $display("Test %s: %0d failures", name, fails);
    fails_before = errors + stalls;
  endtask

  initial begin
    int k;
    int s;
    cpu_req       = '0;
    rst_lck       = 1'b0;
    post_ref      = 8'h00;
    ctrl_ref      = 1'b0;
    exp_rdata     = 16'h0000;
    scan_on       = 1'b0;
    frame_restart = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_lck = 1'b1;
    repeat (4) @(negedge clk);
    report_test("1 reset state");

    bus_write(io_addr(16'h0080), 2'b01, 16'h00A5);
    bus_read(io_addr(16'h0080));
    bus_write(io_addr(16'h0080), 2'b10, 16'h5A00);  // High lane only
    bus_read(io_addr(16'h0081));
    bus_read(io_addr(16'hF200));
    bus_read(io_addr(16'h0300));
    report_test("2 post code and io decode");

    for (k = 0; k < 4; k++) begin
      for (s = 3; s >= 0; s--) begin
        bus_write(mem_addr(20'h01000 + 20'(k * 36)), 2'(s),
                  16'(k * 16'h0123 + s * 16'h1010 + 16'h3C00));
        bus_read(mem_addr(20'h01000 + 20'(k * 36)));
      end
    end
    report_test("3 base ram byte selects");

    for (k = 0; k < soc_pkg::FRAME_WORDS; k++) begin
      bus_write(mem_addr(20'hA0000 + 20'(2 * k)), 2'b11, 16'(16'hC0DE ^ (k * 16'h0111)));
    end
    ready_mode = READY_RANDOM;
    bus_write(io_addr(16'hF200), 2'b01, 16'h0001);
    scan_on = 1'b1;
    wait_words(soc_pkg::FRAME_WORDS * 4);
    report_test("4 scanout under back-pressure");

    ready_mode = READY_HIGH;
    for (k = 0; k < 6; k++) begin
      bus_write(mem_addr(20'h02000 + 20'(2 * k)), 2'b11, 16'(k * 16'h1357 + 16'h0F0F));
      bus_read(mem_addr(20'h02000 + 20'(2 * k)));
      bus_read(mem_addr(20'hA0000 + 20'(2 * k)));
    end
    report_test("5 cpu access during scanout");

    bus_write(io_addr(16'hF200), 2'b01, 16'h0000);
    scan_on = 1'b0;
    wait_drain();
    @(negedge clk);
    frame_restart = 1'b1;  // Next frame starts at offset 0
    @(negedge clk);
    frame_restart = 1'b0;
    bus_write(io_addr(16'hF200), 2'b01, 16'h0001);
    scan_on = 1'b1;
    wait_words(soc_pkg::FRAME_WORDS);
    report_test("6 stop and restart");

    $display("Checks passed: %0d, errors: %0d, stalls: %0d", passes, errors, stalls);
    if (errors == 0 && stalls == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: filelist.f
hdl/soc_pkg.sv
hdl/cpu_bus_switch.sv
hdl/mem_arbiter.sv
hdl/scanout_reader.sv
hdl/shared_mem.sv
hdl/soc_top.sv
bench/tb_soc_top.sv

// File: Makefile
TOP       ?= tb_soc_top
SEED      ?= 32'h97ea1701
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) "-GSEED=$(SEED)" \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
